// File: lsu_fwd.f
common/lsu_fwd_pkg.sv
verilog/lsu_pipe_track.sv
forward/lsu_stage_hit.sv
forward/lsu_fwd_merge.sv
verilog/lsu_coalesce_chk.sv
verilog/lsu_bus_intf.sv
testbench/tb_lsu_model.sv
testbench/tb_lsu_bus_intf.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the lsu forwarding testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_lsu_bus_intf \
   -f lsu_fwd.f -o sim_lsu_fwd || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/sim_lsu_fwd 2>&1)
echo "$sim_out"

# the testbench prints the pass line only when every check held
echo "$sim_out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1

// File: testbench/tb_lsu_bus_intf.sv
`timescale 1ns/1ps

module tb_lsu_bus_intf;

   import lsu_fwd_pkg::*;
   import tb_lsu_model::*;

   localparam int CLK_HALF      = 20;      // 40 ns clock
   localparam int RESET_CYCLES  = 3;
   localparam int BUBBLE_CYCLES = 8;       // quiet pipe right after reset
   localparam int CHECK_START   = 4;
   localparam int NUM_CYCLES    = 3000;
   localparam int MAX_CYCLES    = 30000;   // give up on coverage here
   localparam int MIN_FULL_HITS = 40;
   localparam int MIN_DUAL_HITS = 5;

   logic      clk;
   logic      reset;
   lsu_req_t  req_dc1;
   lsu_word_t ld_bus_data_dc3;
   lsu_word_t bus_read_data_dc3;
   logic      ld_full_hit_dc3;
   logic      lsu_busreq_dc5;
   logic      no_word_merge_dc5;
   logic      no_dword_merge_dc5;
   logic      is_aligned_dc5;

   int        seed;
   int        cycle;
   int        full_hits;
   int        dual_hits;
   logic      exp_full_dc3;
   lsu_word_t exp_fwd_dc3;
   int        err_full_hit, err_read_data, err_busreq;
   int        err_word_merge, err_dword_merge, err_aligned, err_other;

   lsu_bus_intf i_dut (
      .clk                (clk),
      .reset              (reset),
      .req_dc1            (req_dc1),
      .ld_bus_data_dc3    (ld_bus_data_dc3),
      .bus_read_data_dc3  (bus_read_data_dc3),
      .ld_full_hit_dc3    (ld_full_hit_dc3),
      .lsu_busreq_dc5     (lsu_busreq_dc5),
      .no_word_merge_dc5  (no_word_merge_dc5),
      .no_dword_merge_dc5 (no_dword_merge_dc5),
      .is_aligned_dc5     (is_aligned_dc5)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   //**************************************************
   // random requests around two double words
   //**************************************************
   function automatic lsu_req_t random_request();
      lsu_req_t r;
      int       size;
      r    = '0;
      size = 4;
      if (($random(seed) & 7) != 0) begin                // roughly one bubble in eight
         r.pkt.valid = 1'b1;
         if (($random(seed) & 7) < 5) begin
            r.pkt.store = 1'b1;                          // stores a bit more often
         end else begin
            r.pkt.load = 1'b1;
         end
         case ($unsigned($random(seed)) % 3)
            0: begin
               r.pkt.by = 1'b1;
               size     = 1;
            end
            1: begin
               r.pkt.half = 1'b1;
               size       = 2;
            end
            default: begin
               r.pkt.word = 1'b1;
               size       = 4;
            end
         endcase
         r.addr        = 32'h0000_2000 + ($unsigned($random(seed)) % 32'd16);
         r.end_addr    = r.addr + lsu_addr_t'(size - 1);
         r.busreq      = (($random(seed) & 7) != 0);
         r.sideeffects = (($random(seed) & 7) == 0);
         r.store_data  = $random(seed);
      end
      return r;
   endfunction

   task automatic check_outputs();
      lsu_word_t exp_data;
      logic      exp_wm;
      logic      exp_dwm;
      logic      exp_align;
      exp_data  = exp_full_dc3 ? exp_fwd_dc3 : ld_bus_data_dc3;
      exp_wm    = expect_no_merge(WORD_OFS_BITS);
      exp_dwm   = expect_no_merge(DWORD_OFS_BITS);
      exp_align = expect_aligned();
      assert (ld_full_hit_dc3 == exp_full_dc3) else begin
         err_full_hit++;
         $display("ERR ld_full_hit_dc3 got %h exp %h", ld_full_hit_dc3, exp_full_dc3);
      end
      assert (bus_read_data_dc3 == exp_data) else begin
         err_read_data++;
         $display("ERR bus_read_data_dc3 got %h exp %h", bus_read_data_dc3, exp_data);
      end
      assert (lsu_busreq_dc5 == hist[3].busreq) else begin
         err_busreq++;
         $display("ERR lsu_busreq_dc5 got %h exp %h", lsu_busreq_dc5, hist[3].busreq);
      end
      assert (no_word_merge_dc5 == exp_wm) else begin
         err_word_merge++;
         $display("ERR no_word_merge_dc5 got %h exp %h", no_word_merge_dc5, exp_wm);
      end
      assert (no_dword_merge_dc5 == exp_dwm) else begin
         err_dword_merge++;
         $display("ERR no_dword_merge_dc5 got %h exp %h", no_dword_merge_dc5, exp_dwm);
      end
      assert (is_aligned_dc5 == exp_align) else begin
         err_aligned++;
         $display("ERR is_aligned_dc5 got %h exp %h", is_aligned_dc5, exp_align);
      end
   endtask

   //**************************************************
   // main sequence
   //**************************************************
   initial begin : run
      logic      nxt_full;
      lsu_word_t nxt_fwd;
      int        total;
      seed            = 32'h3eff;
      cycle           = 0;
      full_hits       = 0;
      dual_hits       = 0;
      err_full_hit    = 0;
      err_read_data   = 0;
      err_busreq      = 0;
      err_word_merge  = 0;
      err_dword_merge = 0;
      err_aligned     = 0;
      err_other       = 0;
      exp_full_dc3    = 1'b0;
      exp_fwd_dc3     = '0;
      reset           = 1'b1;
      req_dc1         = '0;
      ld_bus_data_dc3 = '0;
      clear_history();
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      while ((cycle < NUM_CYCLES || full_hits < MIN_FULL_HITS || dual_hits < MIN_DUAL_HITS)
             && cycle < MAX_CYCLES) begin
         @(posedge clk);
         push_request(req_dc1);                          // value dc2 captured at this edge
         if (cycle < BUBBLE_CYCLES) begin
            req_dc1 <= '0;
         end else begin
            req_dc1 <= random_request();
         end
         ld_bus_data_dc3 <= $random(seed);
         @(negedge clk);                                 // outputs settled here
         if (cycle >= CHECK_START) begin
            check_outputs();
         end
         expect_forward(nxt_full, nxt_fwd);
         exp_full_dc3 = nxt_full;
         exp_fwd_dc3  = nxt_fwd;
         if (nxt_full) begin
            full_hits++;
            if (is_dual(hist[0])) begin
               dual_hits++;
            end
         end
         cycle++;
      end

      if (full_hits < MIN_FULL_HITS || dual_hits < MIN_DUAL_HITS) begin
         err_other++;
         $display("timeout: only %0d full hits and %0d dual full hits after %0d cycles",
                  full_hits, dual_hits, cycle);
      end

      total = err_full_hit + err_read_data + err_busreq + err_word_merge +
              err_dword_merge + err_aligned + err_other;
      $display("errors hit=%0d data=%0d busreq=%0d wm=%0d dwm=%0d align=%0d other=%0d total=%0d",
               err_full_hit, err_read_data, err_busreq, err_word_merge,
               err_dword_merge, err_aligned, err_other, total);
      if (total == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: testbench/tb_lsu_model.sv
package tb_lsu_model;

   import lsu_fwd_pkg::*;

   localparam int HIST_DEPTH = 4;   // dc2 .. dc5

   // request history from dc2 at index 0 (youngest) to dc5 at index 3
   lsu_req_t hist [HIST_DEPTH];

   function automatic void clear_history();
      for (int i = 0; i < HIST_DEPTH; i++) begin
         hist[i] = '0;
      end
   endfunction

   // each clock the old dc1 request enters dc2
   function automatic void push_request(lsu_req_t req);
      for (int i = HIST_DEPTH - 1; i > 0; i--) begin
         hist[i] = hist[i-1];
      end
      hist[0] = req;
   endfunction

   function automatic int req_size(lsu_req_t req);
      if (req.pkt.word) begin
         return 4;
      end else if (req.pkt.half) begin
         return 2;
      end else if (req.pkt.by) begin
         return 1;
      end
      return 0;
   endfunction

   // first and last byte sit in different words
   function automatic logic is_dual(lsu_req_t req);
      return (req.addr >> 2) != (req.end_addr >> 2);
   endfunction

   //**************************************************
   // store to load forwarding byte by byte
   //**************************************************
   function automatic void store_byte(input lsu_addr_t a, output logic hit,
                                      output logic [7:0] data);
      lsu_req_t st;
      hit  = 1'b0;
      data = '0;
      for (int s = 1; s < HIST_DEPTH; s++) begin   // dc3 first so the youngest store wins
         st = hist[s];
         if (!hit && st.pkt.valid && st.pkt.store && a >= st.addr && a <= st.end_addr) begin
            hit  = 1'b1;
            data = 8'(st.store_data >> (8 * (a - st.addr)));
         end
      end
   endfunction

   // result for the load now in dc2 as seen at dc3 one clock later
   function automatic void expect_forward(output logic full_hit, output lsu_word_t data);
      lsu_req_t   ld;
      logic       hit;
      logic [7:0] b;
      ld       = hist[0];
      full_hit = ld.pkt.valid & ld.pkt.load & ld.busreq & ~ld.sideeffects;
      data     = '0;
      for (int k = 0; k < req_size(ld); k++) begin
         store_byte(ld.addr + lsu_addr_t'(k), hit, b);
         if (hit) begin
            data = data | (lsu_word_t'(b) << (8 * k));   // load byte k lands at byte k
         end else begin
            full_hit = 1'b0;
         end
      end
   endfunction

   //**************************************************
   // dc5 coalescing rules
   //**************************************************
   function automatic logic expect_no_merge(int ofs_bits);
      lsu_req_t old_req;
      lsu_req_t yng;
      logic     found;
      old_req = hist[HIST_DEPTH-1];
      yng     = '0;
      found   = 1'b0;
      for (int s = HIST_DEPTH - 2; s >= 0; s--) begin   // dc4 then dc3 then dc2
         if (!found && hist[s].busreq) begin
            found = 1'b1;
            yng   = hist[s];
         end
      end
      return old_req.busreq && !is_dual(old_req) && found &&
             (yng.pkt.load || ((yng.addr >> ofs_bits) != (old_req.addr >> ofs_bits)));
   endfunction

   function automatic logic expect_aligned();
      lsu_req_t r;
      r = hist[HIST_DEPTH-1];
      return (r.pkt.word && (r.addr % 4) == 0) || (r.pkt.half && (r.addr % 2) == 0);
   endfunction

endpackage

// File: verilog/lsu_bus_intf.sv
`timescale 1ns/1ps

module lsu_bus_intf (
   input  logic                   clk,
   input  logic                   reset,

   input  lsu_fwd_pkg::lsu_req_t  req_dc1,             // new request, valid low = bubble
   input  lsu_fwd_pkg::lsu_word_t ld_bus_data_dc3,     // return data from the bus

   output lsu_fwd_pkg::lsu_word_t bus_read_data_dc3,   // final load data
   output logic                   ld_full_hit_dc3,     // load served from older stores
   output logic                   lsu_busreq_dc5,
   output logic                   no_word_merge_dc5,
   output logic                   no_dword_merge_dc5,
   output logic                   is_aligned_dc5
);

   import lsu_fwd_pkg::*;

   lsu_stage_t stage_dc2;
   lsu_stage_t stage_dc3;
   lsu_stage_t stage_dc4;
   lsu_stage_t stage_dc5;

   //**************************************************
   // pipeline of request views
   //**************************************************
   lsu_pipe_track i_pipe_track (
      .clk       (clk),
      .reset     (reset),
      .req_dc1   (req_dc1),
      .stage_dc2 (stage_dc2),
      .stage_dc3 (stage_dc3),
      .stage_dc4 (stage_dc4),
      .stage_dc5 (stage_dc5)
   );

   // store to load forwarding
   lsu_fwd_merge i_fwd_merge (
      .clk               (clk),
      .reset             (reset),
      .stage_dc2         (stage_dc2),
      .stage_dc3         (stage_dc3),
      .stage_dc4         (stage_dc4),
      .stage_dc5         (stage_dc5),
      .ld_bus_data_dc3   (ld_bus_data_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3),
      .ld_full_hit_dc3   (ld_full_hit_dc3)
   );

   // can the dc5 store be coalesced with what follows
   lsu_coalesce_chk i_coalesce_chk (
      .stage_dc2          (stage_dc2),
      .stage_dc3          (stage_dc3),
      .stage_dc4          (stage_dc4),
      .stage_dc5          (stage_dc5),
      .no_word_merge_dc5  (no_word_merge_dc5),
      .no_dword_merge_dc5 (no_dword_merge_dc5),
      .is_aligned_dc5     (is_aligned_dc5)
   );

   assign lsu_busreq_dc5 = stage_dc5.busreq;

endmodule

// File: verilog/lsu_coalesce_chk.sv
`timescale 1ns/1ps

module lsu_coalesce_chk (
   input  lsu_fwd_pkg::lsu_stage_t stage_dc2,
   input  lsu_fwd_pkg::lsu_stage_t stage_dc3,
   input  lsu_fwd_pkg::lsu_stage_t stage_dc4,
   input  lsu_fwd_pkg::lsu_stage_t stage_dc5,

   output logic                    no_word_merge_dc5,    // dc5 store goes out alone as a word
   output logic                    no_dword_merge_dc5,   // same for a double word
   output logic                    is_aligned_dc5
);

   import lsu_fwd_pkg::*;

   logic word_match_dc4, word_match_dc3, word_match_dc2;
   logic dw_match_dc4, dw_match_dc3, dw_match_dc2;
   logic yng_vld;          // some younger bus request exists
   logic yng_load;
   logic yng_word_match;
   logic yng_dw_match;

   // address compare against each younger stage
   assign word_match_dc4 = (stage_dc5.addr[31:WORD_OFS_BITS] == stage_dc4.addr[31:WORD_OFS_BITS]);
   assign word_match_dc3 = (stage_dc5.addr[31:WORD_OFS_BITS] == stage_dc3.addr[31:WORD_OFS_BITS]);
   assign word_match_dc2 = (stage_dc5.addr[31:WORD_OFS_BITS] == stage_dc2.addr[31:WORD_OFS_BITS]);

   assign dw_match_dc4 = (stage_dc5.addr[31:DWORD_OFS_BITS] == stage_dc4.addr[31:DWORD_OFS_BITS]);
   assign dw_match_dc3 = (stage_dc5.addr[31:DWORD_OFS_BITS] == stage_dc3.addr[31:DWORD_OFS_BITS]);
   assign dw_match_dc2 = (stage_dc5.addr[31:DWORD_OFS_BITS] == stage_dc2.addr[31:DWORD_OFS_BITS]);

   //**************************************************
   // nearest younger bus request, dc4 first
   //**************************************************
   always_comb begin
      yng_vld        = 1'b0;
      yng_load       = 1'b0;
      yng_word_match = 1'b0;
      yng_dw_match   = 1'b0;
      if (stage_dc4.busreq) begin
         yng_vld        = 1'b1;
         yng_load       = stage_dc4.pkt.load;
         yng_word_match = word_match_dc4;
         yng_dw_match   = dw_match_dc4;
      end else if (stage_dc3.busreq) begin
         yng_vld        = 1'b1;
         yng_load       = stage_dc3.pkt.load;
         yng_word_match = word_match_dc3;
         yng_dw_match   = dw_match_dc3;
      end else if (stage_dc2.busreq) begin
         yng_vld        = 1'b1;
         yng_load       = stage_dc2.pkt.load;
         yng_word_match = word_match_dc2;
         yng_dw_match   = dw_match_dc2;
      end
   end

   // a younger load or a different address ends the merge
   assign no_word_merge_dc5  = stage_dc5.busreq & ~stage_dc5.dual & yng_vld &
                               (yng_load | ~yng_word_match);
   assign no_dword_merge_dc5 = stage_dc5.busreq & ~stage_dc5.dual & yng_vld &
                               (yng_load | ~yng_dw_match);

   assign is_aligned_dc5 = (stage_dc5.pkt.word & (stage_dc5.addr[WORD_OFS_BITS-1:0] == '0)) |
                           (stage_dc5.pkt.half & ~stage_dc5.addr[0]);   // halfword on even byte

endmodule

// File: forward/lsu_fwd_merge.sv
`timescale 1ns/1ps

module lsu_fwd_merge (
   input  logic                    clk,
   input  logic                    reset,

   input  lsu_fwd_pkg::lsu_stage_t stage_dc2,
   input  lsu_fwd_pkg::lsu_stage_t stage_dc3,
   input  lsu_fwd_pkg::lsu_stage_t stage_dc4,
   input  lsu_fwd_pkg::lsu_stage_t stage_dc5,
   input  lsu_fwd_pkg::lsu_word_t  ld_bus_data_dc3,

   output lsu_fwd_pkg::lsu_word_t  bus_read_data_dc3,
   output logic                    ld_full_hit_dc3
);

   import lsu_fwd_pkg::*;

   lsu_stage_t                     older_st [NUM_FWD_STAGES];   // dc3 at index 0 is youngest
   byte_en_t                       hit_lo   [NUM_FWD_STAGES];
   byte_en_t                       hit_hi   [NUM_FWD_STAGES];
   lsu_word_t                      fwd_lo   [NUM_FWD_STAGES];
   lsu_word_t                      fwd_hi   [NUM_FWD_STAGES];

   byte_en_t                       hit_any_lo, hit_any_hi;
   lsu_word_t                      merged_lo, merged_hi;
   logic [2*$bits(lsu_word_t)-1:0] merged_dw;
   logic                           full_hit_lo_dc2, full_hit_hi_dc2;
   logic                           ld_full_hit_dc2;
   lsu_word_t                      ld_fwddata_dc2;
   lsu_word_t                      ld_fwddata_dc3;

   assign older_st[0] = stage_dc3;
   assign older_st[1] = stage_dc4;
   assign older_st[2] = stage_dc5;

   //**************************************************
   // one compare per older stage
   //**************************************************
   for (genvar g = 0; g < NUM_FWD_STAGES; g++) begin : g_hit
      lsu_stage_hit i_stage_hit (
         .ld      (stage_dc2),
         .st      (older_st[g]),
         .hit_lo  (hit_lo[g]),
         .hit_hi  (hit_hi[g]),
         .data_lo (fwd_lo[g]),
         .data_hi (fwd_hi[g])
      );
   end

   // oldest first so the younger stages overwrite
   always_comb begin
      hit_any_lo = '0;
      hit_any_hi = '0;
      merged_lo  = '0;
      merged_hi  = '0;
      for (int s = NUM_FWD_STAGES-1; s >= 0; s--) begin
         for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (hit_lo[s][i]) begin
               merged_lo[8*i +: 8] = fwd_lo[s][8*i +: 8];
            end
            if (hit_hi[s][i]) begin
               merged_hi[8*i +: 8] = fwd_hi[s][8*i +: 8];
            end
         end
         hit_any_lo = hit_any_lo | hit_lo[s];
         hit_any_hi = hit_any_hi | hit_hi[s];
      end
   end

   // every byte the load wants must be covered
   assign full_hit_lo_dc2 = &(hit_any_lo | ~stage_dc2.byteen_lo);
   assign full_hit_hi_dc2 = &(hit_any_hi | ~stage_dc2.byteen_hi);

   assign ld_full_hit_dc2 = full_hit_lo_dc2 & full_hit_hi_dc2 & stage_dc2.busreq &
                            stage_dc2.pkt.load & ~stage_dc2.sideeffects;

   // bring the load bytes down to bit 0
   assign merged_dw      = {merged_hi, merged_lo};
   assign ld_fwddata_dc2 = lsu_word_t'(merged_dw >> {stage_dc2.addr[WORD_OFS_BITS-1:0], 3'b000});

   //**************************************************
   // dc3 flops and read data select
   //**************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         ld_full_hit_dc3 <= 1'b0;
      end else begin
         ld_full_hit_dc3 <= ld_full_hit_dc2;
      end
   end

   always_ff @(posedge clk) begin
      ld_fwddata_dc3 <= ld_fwddata_dc2;   // forwarded word moves to dc3 with its load
   end

   assign bus_read_data_dc3 = ld_full_hit_dc3 ? ld_fwddata_dc3 : ld_bus_data_dc3;

endmodule

// File: forward/lsu_stage_hit.sv
`timescale 1ns/1ps

module lsu_stage_hit (
   input  lsu_fwd_pkg::lsu_stage_t ld,        // load in dc2
   input  lsu_fwd_pkg::lsu_stage_t st,        // older store candidate

   output lsu_fwd_pkg::byte_en_t   hit_lo,    // load start-word bytes covered
   output lsu_fwd_pkg::byte_en_t   hit_hi,    // load end-word bytes covered
   output lsu_fwd_pkg::lsu_word_t  data_lo,
   output lsu_fwd_pkg::lsu_word_t  data_hi
);

   import lsu_fwd_pkg::*;

   logic     st_gate;
   // naming is <store word>_<load word>
   logic     addr_hit_lo_lo, addr_hit_lo_hi, addr_hit_hi_lo, addr_hit_hi_hi;
   byte_en_t byte_hit_lo_lo, byte_hit_lo_hi, byte_hit_hi_lo, byte_hit_hi_hi;

   // only a valid store can forward, and only to a bus load
   assign st_gate = st.pkt.valid & st.pkt.store & ld.busreq;

   //**************************************************
   // word address compares
   //**************************************************
   assign addr_hit_lo_lo = (ld.addr[31:WORD_OFS_BITS] == st.addr[31:WORD_OFS_BITS]) &
                           st_gate;
   assign addr_hit_lo_hi = (ld.end_addr[31:WORD_OFS_BITS] == st.addr[31:WORD_OFS_BITS]) &
                           st_gate;
   assign addr_hit_hi_lo = (ld.addr[31:WORD_OFS_BITS] == st.end_addr[31:WORD_OFS_BITS]) &
                           st_gate;
   assign addr_hit_hi_hi = (ld.end_addr[31:WORD_OFS_BITS] == st.end_addr[31:WORD_OFS_BITS]) &
                           st_gate;

   // per byte overlap
   always_comb begin
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
         byte_hit_lo_lo[i] = addr_hit_lo_lo & st.byteen_lo[i] & ld.byteen_lo[i];
         byte_hit_lo_hi[i] = addr_hit_lo_hi & st.byteen_lo[i] & ld.byteen_hi[i];
         byte_hit_hi_lo[i] = addr_hit_hi_lo & st.byteen_hi[i] & ld.byteen_lo[i];
         byte_hit_hi_hi[i] = addr_hit_hi_hi & st.byteen_hi[i] & ld.byteen_hi[i];
      end
   end

   assign hit_lo = byte_hit_lo_lo | byte_hit_hi_lo;
   assign hit_hi = byte_hit_lo_hi | byte_hit_hi_hi;

   //**************************************************
   // pick the store byte that covers each load byte
   //**************************************************
   always_comb begin
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
         data_lo[8*i +: 8] = ({8{byte_hit_lo_lo[i]}} & st.data_lo[8*i +: 8]) |
                             ({8{byte_hit_hi_lo[i]}} & st.data_hi[8*i +: 8]);
         data_hi[8*i +: 8] = ({8{byte_hit_lo_hi[i]}} & st.data_lo[8*i +: 8]) |
                             ({8{byte_hit_hi_hi[i]}} & st.data_hi[8*i +: 8]);
      end
   end

endmodule

// File: verilog/lsu_pipe_track.sv
`timescale 1ns/1ps

module lsu_pipe_track (
   input  logic                    clk,
   input  logic                    reset,

   input  lsu_fwd_pkg::lsu_req_t   req_dc1,

   output lsu_fwd_pkg::lsu_stage_t stage_dc2,
   output lsu_fwd_pkg::lsu_stage_t stage_dc3,
   output lsu_fwd_pkg::lsu_stage_t stage_dc4,
   output lsu_fwd_pkg::lsu_stage_t stage_dc5
);

   import lsu_fwd_pkg::*;

   localparam int NUM_STAGES = 4;   // dc2 .. dc5

   lsu_stage_t                            stage_dc1;
   byte_en_t                              byteen_dc1;     // size mask before shifting
   logic [2*BYTES_PER_WORD-1:0]           byteen_ext_dc1;
   logic [2*$bits(lsu_word_t)-1:0]        data_ext_dc1;
   logic [WORD_OFS_BITS-1:0]              ofs_dc1;
   lsu_stage_t                            stage_q [NUM_STAGES];

   assign ofs_dc1 = req_dc1.addr[WORD_OFS_BITS-1:0];

   //**************************************************
   // dc1 view: masks and aligned data
   //**************************************************
   assign byteen_dc1 = ({BYTES_PER_WORD{req_dc1.pkt.by}}   & byte_en_t'(4'b0001)) |
                       ({BYTES_PER_WORD{req_dc1.pkt.half}} & byte_en_t'(4'b0011)) |
                       ({BYTES_PER_WORD{req_dc1.pkt.word}} & byte_en_t'(4'b1111));

   // shift into a two word window, lo then hi
   assign byteen_ext_dc1 = {{BYTES_PER_WORD{1'b0}}, byteen_dc1} << ofs_dc1;
   assign data_ext_dc1   = {{$bits(lsu_word_t){1'b0}}, req_dc1.store_data} << {ofs_dc1, 3'b000};

   always_comb begin
      stage_dc1.pkt         = req_dc1.pkt;
      stage_dc1.addr        = req_dc1.addr;
      stage_dc1.end_addr    = req_dc1.end_addr;
      stage_dc1.busreq      = req_dc1.busreq;
      stage_dc1.sideeffects = req_dc1.sideeffects;
      // start and end land in different words
      stage_dc1.dual        = (req_dc1.addr[DUAL_BIT] != req_dc1.end_addr[DUAL_BIT]);
      stage_dc1.byteen_lo   = byteen_ext_dc1[BYTES_PER_WORD-1:0];
      stage_dc1.byteen_hi   = byteen_ext_dc1[2*BYTES_PER_WORD-1:BYTES_PER_WORD];
      stage_dc1.data_lo     = data_ext_dc1[$bits(lsu_word_t)-1:0];
      stage_dc1.data_hi     = data_ext_dc1[2*$bits(lsu_word_t)-1:$bits(lsu_word_t)];
   end

   //**************************************************
   // dc2 .. dc5 flops
   //**************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_STAGES; i++) begin
            stage_q[i].pkt    <= '0;            // kills every slot
            stage_q[i].busreq <= 1'b0;
         end
      end else begin
         stage_q[0] <= stage_dc1;
         for (int i = 1; i < NUM_STAGES; i++) begin
            stage_q[i] <= stage_q[i-1];         // one stage per clock
         end
      end
   end

   assign stage_dc2 = stage_q[0];
   assign stage_dc3 = stage_q[1];
   assign stage_dc4 = stage_q[2];
   assign stage_dc5 = stage_q[3];

endmodule

// File: common/lsu_fwd_pkg.sv
package lsu_fwd_pkg;

   //**************************************************
   // sizes fixed by the 32-bit ISA
   //**************************************************
   localparam int BYTES_PER_WORD  = 4;
   localparam int WORD_OFS_BITS   = 2;   // byte offset inside a word
   localparam int DWORD_OFS_BITS  = 3;   // byte offset inside a double word
   localparam int DUAL_BIT        = 2;   // start/end differ here -> access spans two words
   localparam int NUM_FWD_STAGES  = 3;   // dc3, dc4, dc5 can forward to dc2

   // plain vector types
   typedef logic [31:0]               lsu_addr_t;
   typedef logic [31:0]               lsu_word_t;
   typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

   // decoded lsu packet
   typedef struct packed {
      logic valid;
      logic load;
      logic store;
      logic by;
      logic half;
      logic word;
   } lsu_pkt_t;

   //**************************************************
   // request as it enters dc1
   //**************************************************
   typedef struct packed {
      lsu_pkt_t  pkt;
      lsu_addr_t addr;
      lsu_addr_t end_addr;      // last byte touched
      logic      busreq;        // goes out on the bus
      logic      sideeffects;   // side-effect region
      lsu_word_t store_data;
   } lsu_req_t;

   //**************************************************
   // per-stage view carried from dc2 to dc5
   //**************************************************
   typedef struct packed {
      lsu_pkt_t  pkt;
      lsu_addr_t addr;
      lsu_addr_t end_addr;
      logic      busreq;
      logic      sideeffects;
      logic      dual;          // access crosses a word boundary
      byte_en_t  byteen_lo;     // bytes in the start word
      byte_en_t  byteen_hi;     // bytes in the following word
      lsu_word_t data_lo;       // store data aligned to the start word
      lsu_word_t data_hi;       // spill into the next word
   } lsu_stage_t;

endpackage
